// File: sim.f
common/tictactoe_pkg.sv
source/board_state.sv
source/game_judge.sv
source/display_driver.sv
source/tictactoe_top.sv
testbench/tictactoe_checker.sv
testbench/tictactoe_tb.sv

// File: Bender.yml
package:
  name: tictactoe

sources:
  - files:
      - common/tictactoe_pkg.sv
      - source/board_state.sv
      - source/game_judge.sv
      - source/display_driver.sv
      - source/tictactoe_top.sv
  - target: simulation
    files:
      - testbench/tictactoe_checker.sv
      - testbench/tictactoe_tb.sv

// File: testbench/tictactoe_tb.sv
`default_nettype none

// directed and random games on the tic-tac-toe top level
module tictactoe_tb
	import tictactoe_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period = 4;
	// drive edge, clear edge, three pipeline edges and the settle point
	localparam int move_cycles = 5;
	localparam int reset_cycles = 6;
	localparam int directed_moves = 30;
	localparam int random_games = 8;
	localparam int max_moves = 20;
	// twice the expected run length, so a slow run still finishes
	localparam int run_limit = 2 * clk_period * ((directed_moves
		+ random_games * (max_moves + 1)) * move_cycles + (5 + random_games) * reset_cycles);

	logic       clk;
	logic       reset;
	cell_mask_t p1_switches;
	cell_mask_t p2_switches;
	logic       p1_commit;
	logic       p2_commit;
	seg_t       board_left;
	seg_t       board_middle;
	seg_t       board_right;
	seg_t       outcome_segments;
	cell_mask_t p1_leds;
	cell_mask_t p2_leds;

	int errors = 0;
	int checker_seen = 0;
	int tests_run = 0;
	int moves;
	logic [31:0] rng_state = 32'h8a72;

	tictactoe_top uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		p1_commit <= 1'b0;
		p2_commit <= 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
	endtask

	// one strobe per player, then wait until the move reaches every output
	task automatic play(input cell_mask_t p1_cells, input logic p1_go,
		input cell_mask_t p2_cells, input logic p2_go);
		@(posedge clk);
		p1_switches <= p1_cells;
		p2_switches <= p2_cells;
		p1_commit <= p1_go;
		p2_commit <= p2_go;
		@(posedge clk);
		p1_commit <= 1'b0;
		p2_commit <= 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic move_p1(input int k);
		play(cell_mask_t'(1) << k, 1'b1, '0, 1'b0);
	endtask

	task automatic move_p2(input int k);
		play('0, 1'b0, cell_mask_t'(1) << k, 1'b1);
	endtask

	task automatic compare(input string name, input logic [8:0] expected, input logic [8:0] actual);
		assert (expected === actual)
		else
		begin
			errors++;
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// the bound checker counts its own failures, which are folded in here
	task automatic finish_test(input string name);
		assert (uut.checker_inst.violations == checker_seen)
		else
		begin
			errors++;
			$display("checker assertions failed during test %s", name);
		end
		checker_seen = uut.checker_inst.violations;
		tests_run++;
		$display("test %s finished, %0d errors so far", name, errors);
	endtask

	initial
	begin
		reset = 1'b1;
		p1_switches = '0;
		p2_switches = '0;
		p1_commit = 1'b0;
		p2_commit = 1'b0;

		apply_reset();
		compare("board_left", seg_blank, board_left);
		compare("board_middle", seg_blank, board_middle);
		compare("board_right", seg_blank, board_right);
		compare("outcome_segments", seg_blank, outcome_segments);
		compare("p1_leds", '0, p1_leds);
		compare("p2_leds", '0, p2_leds);
		finish_test("reset_state");

		// the centre lights the middle segment of the middle digit
		move_p1(4);
		compare("p1_leds", 9'b000_010_000, p1_leds);
		compare("board_middle", 7'b011_1111, board_middle);
		// player two bids for the taken centre and the free corner, and only gets the corner
		play('0, 1'b0, 9'b000_010_001, 1'b1);
		compare("p2_leds", 9'b100_000_000, p2_leds);
		// both players want cell 8 in the same cycle
		play(9'b100_000_000, 1'b1, 9'b100_000_000, 1'b1);
		compare("p1_leds", 9'b000_010_001, p1_leds);
		finish_test("claim_cells");

		apply_reset();
		move_p1(0);
		move_p2(3);
		move_p1(1);
		move_p2(4);
		move_p1(2);
		compare("outcome_segments", seg_one, outcome_segments);
		play('1, 1'b1, '1, 1'b1);
		compare("p1_leds", 9'b111_000_000, p1_leds);
		compare("p2_leds", 9'b000_110_000, p2_leds);
		finish_test("p1_wins");

		apply_reset();
		move_p1(0);
		move_p2(3);
		move_p1(1);
		move_p2(4);
		move_p1(8);
		move_p2(5);
		compare("outcome_segments", seg_two, outcome_segments);
		move_p1(2);
		compare("p1_leds", 9'b110_000_001, p1_leds);
		finish_test("p2_wins");

		// ends as x o x / x o o / o x x with no line for either side
		apply_reset();
		move_p1(0);
		move_p2(4);
		move_p1(8);
		move_p2(1);
		move_p1(7);
		move_p2(6);
		move_p1(2);
		move_p2(5);
		move_p1(3);
		compare("outcome_segments", seg_dash, outcome_segments);
		finish_test("tie");

		for (int g = 0; g < random_games; g++)
		begin
			apply_reset();
			moves = 0;
			while (moves < max_moves && outcome_segments == seg_blank)
			begin
				rng_state = xorshift(rng_state);
				// bit 0 picks the player, bit 1 sends both strobes together
				play(rng_state[10:2], rng_state[0] | rng_state[1],
					rng_state[19:11], ~rng_state[0] | rng_state[1]);
				moves++;
			end
			assert (outcome_segments != seg_blank)
			else
			begin
				errors++;
				$display("random game %0d did not end within %0d moves", g, max_moves);
			end
			// one extra move after the end exercises the freeze
			play('1, 1'b1, '1, 1'b1);
			finish_test($sformatf("random_game_%0d", g));
		end

		$display("tests run %0d, failed checks %0d", tests_run, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		#(run_limit);
		$display("watchdog expired after %0d ns before the tests finished", run_limit);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/tictactoe_checker.sv
`default_nettype none

// concurrent checks on the game, bound into every tictactoe_top instance
module tictactoe_checker
	import tictactoe_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input cell_mask_t p1_switches,
	input cell_mask_t p2_switches,
	input logic       p1_commit,
	input logic       p2_commit,
	input seg_t       board_left,
	input seg_t       board_middle,
	input seg_t       board_right,
	input seg_t       outcome_segments,
	input cell_mask_t p1_leds,
	input cell_mask_t p2_leds,
	input board_t     board,
	input outcome_t   outcome
);

	timeunit 1ns;
	timeprecision 1ps;

	// the testbench reads this count at the end of every test
	int violations = 0;

	// cells each player owns, as seen on the LEDs
	cell_mask_t p1_cells;
	cell_mask_t p2_cells;
	cell_mask_t free_cells;
	// cells each strobe should take on this edge, player one first
	cell_mask_t p1_take;
	cell_mask_t p2_take;
	cell_mask_t contested;
	seg_t [2:0] expected_digits;
	// outcome digit expected on the next edge, from the LEDs seen on this one
	seg_t expected_result;

	// LED 8-k belongs to cell k
	function automatic cell_mask_t cells_from_leds(input cell_mask_t leds);
		cell_mask_t cells;
		for (int k = 0; k < cell_count; k++)
			cells[k] = leds[cell_count - 1 - k];
		return cells;
	endfunction

	// rows 0, 1 and 2 of a column sit on segments 0, 6 and 3
	function automatic seg_t digit_for(input cell_mask_t cells, input int column);
		seg_t digit;
		digit = seg_blank;
		if (cells[column])
			digit[0] = 1'b0;
		if (cells[3 + column])
			digit[6] = 1'b0;
		if (cells[6 + column])
			digit[3] = 1'b0;
		return digit;
	endfunction

	// outcome digit by the judging order, player one first and a full board last
	function automatic seg_t result_for(input cell_mask_t p1, input cell_mask_t p2);
		if (has_line(p1))
			return seg_one;
		if (has_line(p2))
			return seg_two;
		if (&(p1 | p2))
			return seg_dash;
		return seg_blank;
	endfunction

	assign p1_cells = cells_from_leds(p1_leds);
	assign p2_cells = cells_from_leds(p2_leds);
	assign free_cells = ~(board.p1 | board.p2);
	assign p1_take = p1_commit ? (p1_switches & free_cells) : '0;
	assign p2_take = p2_commit ? (p2_switches & free_cells & ~p1_take) : '0;
	assign contested = p1_switches & p2_switches & free_cells;
	assign expected_digits = {digit_for(p1_cells | p2_cells, 0),
		digit_for(p1_cells | p2_cells, 1), digit_for(p1_cells | p2_cells, 2)};

	always_ff @(posedge clk)
	begin
		expected_result <= result_for(p1_cells, p2_cells);
	end

	// a cell never lights for both players
	assert property (@(posedge clk) disable iff (reset) (p1_leds & p2_leds) == '0)
	else
	begin
		violations++;
		$error("Fail at %0t: p1_leds and p2_leds share %h", $time,
			$sampled(p1_leds & p2_leds));
	end

	// board digits and LEDs come out of the same stage and always agree
	assert property (@(posedge clk) disable iff (reset)
		{board_left, board_middle, board_right} == expected_digits)
	else
	begin
		violations++;
		$error("Fail at %0t: board digits expected %h, got %h", $time,
			$sampled(expected_digits), $sampled({board_left, board_middle, board_right}));
	end

	// the outcome digit trails the LEDs by one cycle
	assert property (@(posedge clk) disable iff (reset) outcome_segments == expected_result)
	else
	begin
		violations++;
		$error("Fail at %0t: outcome_segments expected %h, got %h", $time,
			$sampled(expected_result), $sampled(outcome_segments));
	end

	// a claim accepted now shows on the LEDs two edges later
	assert property (@(posedge clk) disable iff (reset) (outcome == in_play) |-> ##2
		((p1_cells & $past(p1_take, 2)) == $past(p1_take, 2)
		&& (p2_cells & $past(p2_take, 2)) == $past(p2_take, 2)))
	else
	begin
		violations++;
		$error("Fail at %0t: a committed free cell is missing from its owner's LEDs", $time);
	end

	assert property (@(posedge clk) disable iff (reset)
		(p1_commit && p2_commit && outcome == in_play)
		|=> (board.p1 & $past(contested)) == $past(contested))
	else
	begin
		violations++;
		$error("Fail at %0t: a cell bid by both players did not go to player one", $time);
	end

	// owned cells are kept, and nothing moves once the game is decided
	assert property (@(posedge clk) disable iff (reset)
		(board.p1 & $past(board.p1)) == $past(board.p1)
		&& (board.p2 & $past(board.p2)) == $past(board.p2))
	else
	begin
		violations++;
		$error("Fail at %0t: an owned cell lost its owner", $time);
	end

	assert property (@(posedge clk) disable iff (reset) (outcome != in_play) |=> $stable(board))
	else
	begin
		violations++;
		$error("Fail at %0t: board changed after the game was decided", $time);
	end

endmodule

bind tictactoe_top tictactoe_checker checker_inst (.*);

`default_nettype wire

// File: source/tictactoe_top.sv
`default_nettype none

// two-player game on one shared board, built as a three-stage pipeline
module tictactoe_top
	import tictactoe_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  cell_mask_t p1_switches,
	input  cell_mask_t p2_switches,
	input  logic       p1_commit,
	input  logic       p2_commit,
	output seg_t       board_left,
	output seg_t       board_middle,
	output seg_t       board_right,
	output seg_t       outcome_segments,
	output cell_mask_t p1_leds,
	output cell_mask_t p2_leds
);

	// claim masks from the first stage
	board_t board;

	// registered result, which also goes back to freeze the board
	outcome_t outcome;

	board_state board_state_inst (
		.clk         (clk),
		.reset       (reset),
		.p1_switches (p1_switches),
		.p2_switches (p2_switches),
		.p1_commit   (p1_commit),
		.p2_commit   (p2_commit),
		.outcome     (outcome),
		.board       (board)
	);

	game_judge game_judge_inst (
		.clk     (clk),
		.reset   (reset),
		.board   (board),
		.outcome (outcome)
	);

	display_driver display_driver_inst (
		.clk              (clk),
		.reset            (reset),
		.board            (board),
		.outcome          (outcome),
		.board_left       (board_left),
		.board_middle     (board_middle),
		.board_right      (board_right),
		.outcome_segments (outcome_segments),
		.p1_leds          (p1_leds),
		.p2_leds          (p2_leds)
	);

endmodule

`default_nettype wire

// File: source/display_driver.sv
`default_nettype none

// third pipeline stage, which turns the board and the result into segments and LEDs
module display_driver
	import tictactoe_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  board_t     board,
	input  outcome_t   outcome,
	output seg_t       board_left,
	output seg_t       board_middle,
	output seg_t       board_right,
	output seg_t       outcome_segments,
	output cell_mask_t p1_leds,
	output cell_mask_t p2_leds
);

	// the board digits do not tell the players apart
	cell_mask_t occupied;

	// next value of the outcome digit
	seg_t result_glyph;

	// one digit shows one column, with the top, middle and bottom segments as the rows
	function automatic seg_t column_glyph(input cell_mask_t cells, input int column);
		seg_t glyph;
		glyph = seg_blank;
		// segments are active low, so an owned cell pulls its segment to zero
		glyph[0] = ~cells[column];
		glyph[6] = ~cells[board_side + column];
		glyph[3] = ~cells[2 * board_side + column];
		return glyph;
	endfunction

	// the LED row is wired so that cell k lands on LED 8-k
	function automatic cell_mask_t reverse_mask(input cell_mask_t mask);
		cell_mask_t flipped;
		for (int k = 0; k < cell_count; k++)
		begin
			flipped[cell_count - 1 - k] = mask[k];
		end
		return flipped;
	endfunction

	assign occupied = board.p1 | board.p2;

	always_comb
	begin
		case (outcome)
			p1_wins: result_glyph = seg_one;
			p2_wins: result_glyph = seg_two;
			tie:     result_glyph = seg_dash;
			// the digit stays dark while the game is running
			default: result_glyph = seg_blank;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			board_left       <= seg_blank;
			board_middle     <= seg_blank;
			board_right      <= seg_blank;
			outcome_segments <= seg_blank;
			p1_leds          <= '0;
			p2_leds          <= '0;
		end
		else
		begin
			board_left       <= column_glyph(occupied, 0);
			board_middle     <= column_glyph(occupied, 1);
			board_right      <= column_glyph(occupied, 2);
			outcome_segments <= result_glyph;
			p1_leds          <= reverse_mask(board.p1);
			p2_leds          <= reverse_mask(board.p2);
		end
	end

endmodule

`default_nettype wire

// File: source/game_judge.sv
`default_nettype none

// second pipeline stage, which decides the state of the game from the board
module game_judge
	import tictactoe_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  board_t   board,
	output outcome_t outcome
);

	// line checks for each player
	logic p1_line;
	logic p2_line;

	// every cell has an owner
	logic board_full;

	// result for the current board, registered on the next edge
	outcome_t judged;

	assign p1_line = has_line(board.p1);
	assign p2_line = has_line(board.p2);
	assign board_full = &(board.p1 | board.p2);

	always_comb
	begin
		// a line for player one is checked first and outranks everything else
		if (p1_line)
			judged = p1_wins;
		else if (p2_line)
			judged = p2_wins;
		// a full board with no line is a draw
		else if (board_full)
			judged = tie;
		else
			judged = in_play;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			outcome <= in_play;
		else
			outcome <= judged;
	end

endmodule

`default_nettype wire

// File: source/board_state.sv
`default_nettype none

// first pipeline stage, which owns the two claim masks of the board
module board_state
	import tictactoe_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  cell_mask_t p1_switches,
	input  cell_mask_t p2_switches,
	input  logic       p1_commit,
	input  logic       p2_commit,
	input  outcome_t   outcome,
	output board_t     board
);

	// cells that neither player has taken yet
	cell_mask_t free_cells;

	// cells each player takes on this edge
	cell_mask_t p1_claim;
	cell_mask_t p2_claim;

	// moves are only accepted while the judge still reports a running game
	logic game_live;

	assign free_cells = ~(board.p1 | board.p2);
	assign game_live = (outcome == in_play);

	always_comb
	begin
		// player one takes every free cell whose switch is up when the strobe arrives
		if (p1_commit)
			p1_claim = p1_switches & free_cells;
		else
			p1_claim = '0;

		// player two only gets what is left once player one has claimed this cycle
		// so a cell contested in the same cycle ends up with player one
		if (p2_commit)
			p2_claim = p2_switches & free_cells & ~p1_claim;
		else
			p2_claim = '0;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// a reset clears the board and starts a new game
			board <= '0;
		end
		else if (game_live)
		begin
			// claimed cells are sticky and only ever gain new bits
			board.p1 <= board.p1 | p1_claim;
			board.p2 <= board.p2 | p2_claim;
		end
		// once a result is out the board stays frozen until the next reset
	end

endmodule

`default_nettype wire

// File: common/tictactoe_pkg.sv
`default_nettype none

package tictactoe_pkg;

	// the board is a square of three by three cells
	localparam int board_side = 3;
	localparam int cell_count = board_side * board_side;

	// rows, columns and the two diagonals give eight ways to win
	localparam int line_count = 8;

	// one bit per cell, where cell k sits at row k/3 and column k mod 3
	typedef logic [cell_count-1:0] cell_mask_t;

	// each player keeps a mask of the cells that player has claimed
	typedef struct packed {
		cell_mask_t p1;
		cell_mask_t p2;
	} board_t;

	typedef enum logic [1:0] {
		in_play,
		p1_wins,
		p2_wins,
		tie
	} outcome_t;

	// seven-segment pattern, active low, with bit 0 driving the top segment
	typedef logic [6:0] seg_t;

	localparam seg_t seg_blank = 7'b111_1111;
	localparam seg_t seg_one   = 7'b111_1001;
	localparam seg_t seg_two   = 7'b010_0100;
	// only the middle segment is lit for a drawn game
	localparam seg_t seg_dash  = 7'b011_1111;

	// the three rows come first, then the three columns, then both diagonals
	localparam cell_mask_t win_lines [line_count] = '{
		9'b000_000_111,
		9'b000_111_000,
		9'b111_000_000,
		9'b001_001_001,
		9'b010_010_010,
		9'b100_100_100,
		9'b100_010_001,
		9'b001_010_100
	};

	// true when the mask holds every cell of at least one winning line
	function automatic logic has_line(input cell_mask_t mask);
		logic found;
		found = 1'b0;
		for (int i = 0; i < line_count; i++)
		begin
			if ((mask & win_lines[i]) == win_lines[i])
				found = 1'b1;
		end
		return found;
	endfunction

endpackage

`default_nettype wire
